//--- logic/bomber_pkg.sv
package bomber_pkg;

  // --------------------
  // Tile and direction codes
  // --------------------
  typedef enum logic [1:0] {
    tile_free  = 2'd0,
    tile_solid = 2'd1,  // Cannot be destroyed
    tile_brick = 2'd2   // Cleared by a blast
  } tile_t;

  typedef enum logic [1:0] {
    dir_up    = 2'd0,
    dir_down  = 2'd1,
    dir_left  = 2'd2,
    dir_right = 2'd3
  } dir_t;

  // Blast clearer FSM
  typedef enum logic [1:0] {
    blast_idle,
    blast_wait_grant,
    blast_read,
    blast_clear
  } blast_state_t;

  // --------------------
  // Default geometry and fuse
  // --------------------
  localparam int num_row_def     = 11;
  localparam int num_col_def     = 13;
  localparam int fuse_cycles_def = 20;

  // Address of the cell next to addr in direction dir
  function automatic int neighbor_addr(int addr, dir_t dir, int num_col);
    case (dir)
      dir_up:   return addr - num_col;
      dir_down: return addr + num_col;
      dir_left: return addr - 1;
      default:  return addr + 1;
    endcase
  endfunction

endpackage

//--- logic/map_mem.sv
`timescale 1ns/10ps

module map_mem #(
  parameter int NUM_ROW = bomber_pkg::num_row_def,
  parameter int NUM_COL = bomber_pkg::num_col_def,
  localparam int DEPTH  = NUM_ROW * NUM_COL,
  localparam int ADDR_W = $clog2(DEPTH)
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [ADDR_W-1:0]   rd_addr,
  output bomber_pkg::tile_t   rd_tile,
  input  logic                wr_en,
  input  logic [ADDR_W-1:0]   wr_addr,
  input  bomber_pkg::tile_t   wr_tile
);

  bomber_pkg::tile_t tiles [DEPTH];

  // Start pattern of a fresh map
  function automatic bomber_pkg::tile_t start_tile(int r, int c);
    if (r == 0 || r == NUM_ROW - 1 || c == 0 || c == NUM_COL - 1) begin
      return bomber_pkg::tile_solid;  // Border wall
    end
    if ((r % 2 == 0) && (c % 2 == 0)) begin
      return bomber_pkg::tile_solid;  // Pillar grid
    end
    if ((r + c) % 3 == 0) begin
      return bomber_pkg::tile_brick;
    end
    return bomber_pkg::tile_free;
  endfunction

  // --------------------
  // Tile array, one write port
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < NUM_ROW; r++) begin
        for (int c = 0; c < NUM_COL; c++) begin
          tiles[r*NUM_COL + c] <= start_tile(r, c);
        end
      end
    end else if (wr_en && (wr_addr < DEPTH)) begin
      tiles[wr_addr] <= wr_tile;
    end
  end

  // Registered read, old value on a same-cycle write
  always_ff @(posedge clk) begin
    if (rd_addr < DEPTH) begin
      rd_tile <= tiles[rd_addr];
    end else begin
      rd_tile <= bomber_pkg::tile_solid;  // Off the map acts as wall
    end
  end

endmodule

//--- logic/map_read_arbiter.sv
`timescale 1ns/10ps

module map_read_arbiter #(
  parameter int NUM_ROW = bomber_pkg::num_row_def,
  parameter int NUM_COL = bomber_pkg::num_col_def,
  localparam int ADDR_W = $clog2(NUM_ROW * NUM_COL)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              game_over,
  input  logic              blast_req,
  input  logic [ADDR_W-1:0] blast_rd_addr,
  input  logic              move_req_rd,
  input  logic [ADDR_W-1:0] move_rd_addr,
  output logic              grant_blast,
  output logic              grant_move,
  output logic [ADDR_W-1:0] rd_addr
);

  // --------------------
  // Two-owner lock
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_blast <= 1'b0;
      grant_move  <= 1'b0;
    end else if (game_over) begin
      grant_blast <= 1'b0;
      grant_move  <= 1'b0;
    end else if (grant_blast) begin
      grant_blast <= blast_req;  // Held while requested
    end else if (grant_move) begin
      grant_move <= move_req_rd;
    end else if (blast_req) begin
      grant_blast <= 1'b1;  // Clearer wins a tie
    end else if (move_req_rd) begin
      grant_move <= 1'b1;
    end
  end

  // Address of the current owner
  assign rd_addr = grant_move ? move_rd_addr : blast_rd_addr;

endmodule

//--- logic/bomb_timer.sv
`timescale 1ns/10ps

module bomb_timer #(
  parameter int NUM_ROW     = bomber_pkg::num_row_def,
  parameter int NUM_COL     = bomber_pkg::num_col_def,
  parameter int FUSE_CYCLES = bomber_pkg::fuse_cycles_def,
  localparam int ADDR_W     = $clog2(NUM_ROW * NUM_COL),
  localparam int CNT_W      = $clog2(FUSE_CYCLES + 1)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              game_over,
  input  logic              bomb_drop,
  input  logic [ADDR_W-1:0] bomb_addr,
  input  logic              blast_busy,
  output logic              bomb_armed,
  output logic              explode,
  output logic [ADDR_W-1:0] blast_addr
);

  int         drop_row;
  int         drop_col;
  logic       interior;
  logic       accept;
  logic [CNT_W-1:0] fuse_cnt;

  // Drop cell must not touch the border
  always_comb begin
    drop_row = int'(bomb_addr) / NUM_COL;
    drop_col = int'(bomb_addr) % NUM_COL;
    interior = (drop_row >= 1) && (drop_row <= NUM_ROW - 2) &&
               (drop_col >= 1) && (drop_col <= NUM_COL - 2);
  end

  assign accept = bomb_drop && !bomb_armed && !blast_busy && interior;

  // --------------------
  // Fuse countdown
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bomb_armed <= 1'b0;
      explode    <= 1'b0;
      fuse_cnt   <= '0;
    end else if (game_over) begin
      bomb_armed <= 1'b0;
      explode    <= 1'b0;
      fuse_cnt   <= '0;
    end else begin
      explode <= 1'b0;
      if (accept) begin
        bomb_armed <= 1'b1;
        fuse_cnt   <= CNT_W'(FUSE_CYCLES - 1);
      end else if (bomb_armed) begin
        if (fuse_cnt == '0) begin
          bomb_armed <= 1'b0;  // Fuse burnt out
          explode    <= 1'b1;
        end else begin
          fuse_cnt <= fuse_cnt - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) blast_addr <= bomb_addr;
  end

endmodule

//--- logic/blast_clearer.sv
`timescale 1ns/10ps

module blast_clearer #(
  parameter int NUM_ROW = bomber_pkg::num_row_def,
  parameter int NUM_COL = bomber_pkg::num_col_def,
  localparam int ADDR_W = $clog2(NUM_ROW * NUM_COL)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              game_over,
  input  logic              explode,
  input  logic [ADDR_W-1:0] blast_addr,
  input  logic              grant,
  input  bomber_pkg::tile_t rd_tile,
  output logic              rd_req,
  output logic [ADDR_W-1:0] rd_addr,
  output logic              wr_en,
  output logic [ADDR_W-1:0] wr_addr,
  output bomber_pkg::tile_t wr_tile,
  output logic              blast_busy,
  output logic              blast_done
);

  bomber_pkg::blast_state_t state, state_nxt;

  logic [ADDR_W-1:0] saved_addr;
  logic [ADDR_W-1:0] nb_addr;
  logic [1:0]        dir_cnt;     // Direction being read or cleared
  logic              issue_done;  // All four reads sent
  logic              data_vld;
  logic [1:0]        data_dir;    // Direction of the returning tile
  logic [3:0]        brick_mask;

  // --------------------
  // Next state
  // --------------------
  always_comb begin
    state_nxt = state;
    case (state)
      bomber_pkg::blast_idle:       if (explode) state_nxt = bomber_pkg::blast_wait_grant;
      bomber_pkg::blast_wait_grant: if (grant) state_nxt = bomber_pkg::blast_read;
      bomber_pkg::blast_read:       if (issue_done) state_nxt = bomber_pkg::blast_clear;
      bomber_pkg::blast_clear:      if (dir_cnt == 2'd3) state_nxt = bomber_pkg::blast_idle;
      default:                      state_nxt = bomber_pkg::blast_idle;
    endcase
  end

  // --------------------
  // State, counter and brick mask
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= bomber_pkg::blast_idle;
      dir_cnt    <= '0;
      issue_done <= 1'b0;
      data_vld   <= 1'b0;
      data_dir   <= '0;
      brick_mask <= '0;
    end else if (game_over) begin
      state      <= bomber_pkg::blast_idle;
      dir_cnt    <= '0;
      issue_done <= 1'b0;
      data_vld   <= 1'b0;
      data_dir   <= '0;
      brick_mask <= '0;
    end else begin
      state <= state_nxt;
      case (state)
        bomber_pkg::blast_idle: begin
          dir_cnt    <= '0;
          issue_done <= 1'b0;
          data_vld   <= 1'b0;
          brick_mask <= '0;
        end
        bomber_pkg::blast_read: begin
          if (!issue_done) begin
            dir_cnt <= dir_cnt + 1'b1;  // Wraps to up for the clear pass
            if (dir_cnt == 2'd3) issue_done <= 1'b1;
          end
          data_vld <= !issue_done;
          data_dir <= dir_cnt;
          // Tile of the previous address lands now
          if (data_vld && grant && (rd_tile == bomber_pkg::tile_brick)) begin
            brick_mask[data_dir] <= 1'b1;
          end
        end
        bomber_pkg::blast_clear: dir_cnt <= dir_cnt + 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == bomber_pkg::blast_idle && explode) saved_addr <= blast_addr;
  end

  // Neighbor of the saved cell, shared by read and write
  assign nb_addr = ADDR_W'(bomber_pkg::neighbor_addr(int'(saved_addr),
                                                     bomber_pkg::dir_t'(dir_cnt),
                                                     NUM_COL));

  // Port stays owned through the clear pass, so no other read sees a brick about to go
  assign rd_req  = (state != bomber_pkg::blast_idle);
  assign rd_addr = nb_addr;

  assign wr_en   = (state == bomber_pkg::blast_clear) && brick_mask[dir_cnt];
  assign wr_addr = nb_addr;
  assign wr_tile = bomber_pkg::tile_free;

  assign blast_busy = (state != bomber_pkg::blast_idle);
  assign blast_done = (state == bomber_pkg::blast_clear) && (dir_cnt == 2'd3);

endmodule

//--- logic/move_checker.sv
`timescale 1ns/10ps

module move_checker #(
  parameter int NUM_ROW = bomber_pkg::num_row_def,
  parameter int NUM_COL = bomber_pkg::num_col_def,
  localparam int ADDR_W = $clog2(NUM_ROW * NUM_COL)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              game_over,
  input  logic              move_req,
  input  logic [ADDR_W-1:0] move_addr,
  input  bomber_pkg::dir_t  move_dir,
  input  logic              grant,
  input  bomber_pkg::tile_t rd_tile,
  output logic              rd_req,
  output logic [ADDR_W-1:0] rd_addr,
  output logic              move_done,
  output logic              move_ok
);

  typedef enum logic [1:0] {
    move_idle,
    move_wait_grant,
    move_read,    // Tile returns this cycle
    move_report
  } move_state_t;

  move_state_t       state;
  logic [ADDR_W-1:0] target_addr;

  // --------------------
  // Request handling
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= move_idle;
      move_ok <= 1'b0;
    end else if (game_over) begin
      state   <= move_idle;
      move_ok <= 1'b0;
    end else begin
      case (state)
        move_idle:       if (move_req) state <= move_wait_grant;
        move_wait_grant: if (grant) state <= move_read;  // Address goes out now
        move_read: begin
          move_ok <= grant && (rd_tile == bomber_pkg::tile_free);
          state   <= move_report;
        end
        default:         state <= move_idle;
      endcase
    end
  end

  // Target cell of the step
  always_ff @(posedge clk) begin
    if (state == move_idle && move_req) begin
      target_addr <= ADDR_W'(bomber_pkg::neighbor_addr(int'(move_addr), move_dir, NUM_COL));
    end
  end

  assign rd_req    = (state == move_wait_grant) || (state == move_read);
  assign rd_addr   = target_addr;
  assign move_done = (state == move_report);

endmodule

//--- logic/bomber_map_top.sv
`timescale 1ns/10ps

module bomber_map_top #(
  parameter int NUM_ROW     = bomber_pkg::num_row_def,
  parameter int NUM_COL     = bomber_pkg::num_col_def,
  parameter int FUSE_CYCLES = bomber_pkg::fuse_cycles_def,
  localparam int ADDR_W     = $clog2(NUM_ROW * NUM_COL)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              game_over,
  input  logic              bomb_drop,
  input  logic [ADDR_W-1:0] bomb_addr,
  input  logic              move_req,
  input  logic [ADDR_W-1:0] move_addr,
  input  bomber_pkg::dir_t  move_dir,
  output logic              bomb_armed,
  output logic              blast_busy,
  output logic              blast_done,
  output logic              move_done,
  output logic              move_ok
);

  logic              explode;
  logic [ADDR_W-1:0] blast_addr;
  logic              blast_rd_req, move_rd_req;
  logic [ADDR_W-1:0] blast_rd_addr, move_rd_addr;
  logic              grant_blast, grant_move;
  logic [ADDR_W-1:0] rd_addr;
  bomber_pkg::tile_t rd_tile;
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  bomber_pkg::tile_t wr_tile;

  // --------------------
  // Decode
  // --------------------
  bomb_timer #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL), .FUSE_CYCLES(FUSE_CYCLES)) u_bomb_timer (
    .clk, .rst_n, .game_over, .bomb_drop, .bomb_addr, .blast_busy,
    .bomb_armed, .explode, .blast_addr
  );

  // --------------------
  // Execute
  // --------------------
  blast_clearer #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) u_blast_clearer (
    .clk, .rst_n, .game_over, .explode, .blast_addr,
    .grant(grant_blast), .rd_tile,
    .rd_req(blast_rd_req), .rd_addr(blast_rd_addr),
    .wr_en, .wr_addr, .wr_tile, .blast_busy, .blast_done
  );

  move_checker #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) u_move_checker (
    .clk, .rst_n, .game_over, .move_req, .move_addr, .move_dir,
    .grant(grant_move), .rd_tile,
    .rd_req(move_rd_req), .rd_addr(move_rd_addr), .move_done, .move_ok
  );

  map_read_arbiter #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) u_arbiter (
    .clk, .rst_n, .game_over,
    .blast_req(blast_rd_req), .blast_rd_addr,
    .move_req_rd(move_rd_req), .move_rd_addr,
    .grant_blast, .grant_move, .rd_addr
  );

  // --------------------
  // Result
  // --------------------
  map_mem #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) u_map_mem (
    .clk, .rst_n, .rd_addr, .rd_tile, .wr_en, .wr_addr, .wr_tile
  );

endmodule

//--- tb/clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;  // Released off the edge, like the other inputs
  end

endmodule

//--- tb/tb_bomber_map.sv
`timescale 1ns/10ps

module tb_bomber_map;

  localparam int NUM_ROW        = bomber_pkg::num_row_def;
  localparam int NUM_COL        = bomber_pkg::num_col_def;
  localparam int FUSE_CYCLES    = bomber_pkg::fuse_cycles_def;
  localparam int DEPTH          = NUM_ROW * NUM_COL;
  localparam int ADDR_W         = $clog2(DEPTH);
  localparam int NUM_MOVES      = 40;
  localparam int NUM_BOMBS      = 12;
  localparam int TIMEOUT_CYCLES = NUM_MOVES * 20 + NUM_BOMBS * (FUSE_CYCLES + 40) + 16;

  logic              clk;
  logic              rst_n;
  logic              game_over;
  logic              bomb_drop;
  logic [ADDR_W-1:0] bomb_addr;
  logic              move_req;
  logic [ADDR_W-1:0] move_addr;
  bomber_pkg::dir_t  move_dir;
  logic              bomb_armed;
  logic              blast_busy;
  logic              blast_done;
  logic              move_done;
  logic              move_ok;

  bomber_pkg::tile_t model [DEPTH];  // Expected map contents
  int                seed;
  int                cycle_cnt = 0;

  clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  bomber_map_top #(
    .NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL), .FUSE_CYCLES(FUSE_CYCLES)
  ) dut (
    .clk(clk), .rst_n(rst_n), .game_over(game_over),
    .bomb_drop(bomb_drop), .bomb_addr(bomb_addr),
    .move_req(move_req), .move_addr(move_addr), .move_dir(move_dir),
    .bomb_armed(bomb_armed), .blast_busy(blast_busy), .blast_done(blast_done),
    .move_done(move_done), .move_ok(move_ok)
  );

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("[ERROR] %0t run did not finish within %0d cycles", $time, TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1);
    end
  end

  // --------------------
  // Map model
  // --------------------
  function automatic bomber_pkg::tile_t pattern_tile(int r, int c);
    logic on_border;
    on_border = (r == 0) || (c == 0) || (r == NUM_ROW - 1) || (c == NUM_COL - 1);
    if (on_border || ((r % 2 == 0) && (c % 2 == 0)))
      return bomber_pkg::tile_solid;
    else if ((r + c) % 3 == 0)
      return bomber_pkg::tile_brick;
    else
      return bomber_pkg::tile_free;
  endfunction

  // Cell one step away in a direction
  function automatic int step_cell(int addr, bomber_pkg::dir_t dir);
    int r;
    int c;
    r = addr / NUM_COL;
    c = addr % NUM_COL;
    case (dir)
      bomber_pkg::dir_up:   r = r - 1;
      bomber_pkg::dir_down: r = r + 1;
      bomber_pkg::dir_left: c = c - 1;
      default:              c = c + 1;
    endcase
    return r * NUM_COL + c;
  endfunction

  // Up/down and left/right differ only in the low bit
  function automatic bomber_pkg::dir_t opposite_dir(bomber_pkg::dir_t dir);
    return bomber_pkg::dir_t'(dir ^ 2'd1);
  endfunction

  function automatic int rand_below(int n);
    int unsigned v;
    v = $random(seed);
    return int'(v % n);
  endfunction

  function automatic int random_interior();
    return (1 + rand_below(NUM_ROW - 2)) * NUM_COL + 1 + rand_below(NUM_COL - 2);
  endfunction

  // --------------------
  // Helpers
  // --------------------
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    assert (got === exp) else begin
      $display("[ERROR] %0t %s expected %0b got %0b", $time, name, exp, got);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic fail_now(string what);
    $display("[ERROR] %0t %s", $time, what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic start_move(int source, bomber_pkg::dir_t dir);
    move_addr = ADDR_W'(source);
    move_dir  = dir;
    move_req  = 1'b1;
  endtask

  // Step from source and compare move_ok with the model
  task automatic check_move(int source, bomber_pkg::dir_t dir);
    int target;
    target = step_cell(source, dir);
    start_move(source, dir);
    next_cycle();
    move_req = 1'b0;
    while (move_done !== 1'b1) next_cycle();
    check_bit("move_ok", move_ok, model[target] == bomber_pkg::tile_free);
    next_cycle();  // Checker back to idle
  endtask

  task automatic drop_on_border();
    int r;
    int c;
    r = rand_below(NUM_ROW);
    c = rand_below(NUM_COL);
    case (rand_below(4))
      0:       r = 0;
      1:       r = NUM_ROW - 1;
      2:       c = 0;
      default: c = NUM_COL - 1;
    endcase
    bomb_addr = ADDR_W'(r * NUM_COL + c);
    bomb_drop = 1'b1;
    next_cycle();
    bomb_drop = 1'b0;
    check_bit("bomb_armed", bomb_armed, 1'b0);
  endtask

  // Full bomb with fuse timing, rejected drops and a move racing the blast
  task automatic run_bomb();
    int               bomb_cell;
    int               target;
    int               nb [4];
    bit               blast_seen;
    bit               move_seen;
    bomber_pkg::dir_t dir;
    bomb_cell = random_interior();
    for (int d = 0; d < 4; d++) nb[d] = step_cell(bomb_cell, bomber_pkg::dir_t'(d));
    bomb_addr = ADDR_W'(bomb_cell);
    bomb_drop = 1'b1;
    next_cycle();
    check_bit("bomb_armed", bomb_armed, 1'b1);
    bomb_addr = ADDR_W'(random_interior());  // Second drop while armed
    for (int k = 1; k <= FUSE_CYCLES; k++) begin
      next_cycle();
      bomb_drop = 1'b0;
      check_bit("bomb_armed", bomb_armed, k < FUSE_CYCLES);
      check_bit("blast_busy", blast_busy, 1'b0);
    end
    next_cycle();
    check_bit("blast_busy", blast_busy, 1'b1);
    // Clearer already asks for the port, so the move has to wait
    bomb_addr = ADDR_W'(random_interior());
    bomb_drop = 1'b1;
    // Half of the racing moves step into a blast neighbor
    if (rand_below(2) == 0) begin
      target = nb[rand_below(4)];
    end else begin
      target = random_interior();
    end
    dir = bomber_pkg::dir_t'(rand_below(4));
    start_move(step_cell(target, opposite_dir(dir)), dir);
    blast_seen = 1'b0;
    move_seen  = 1'b0;
    next_cycle();
    bomb_drop = 1'b0;
    move_req  = 1'b0;
    while (!(blast_seen && move_seen && !blast_busy)) begin
      check_bit("bomb_armed", bomb_armed, 1'b0);
      if (!blast_seen) check_bit("blast_busy", blast_busy, 1'b1);
      if (blast_done) begin
        assert (!blast_seen) else fail_now("blast_done pulsed twice for one bomb");
        blast_seen = 1'b1;
        for (int d = 0; d < 4; d++) begin
          if (model[nb[d]] == bomber_pkg::tile_brick) model[nb[d]] = bomber_pkg::tile_free;
        end
      end
      if (move_done) begin
        assert (blast_seen) else fail_now("move finished before the blast gave up the read port");
        assert (!move_seen) else fail_now("move_done pulsed twice for one move");
        check_bit("move_ok", move_ok, model[target] == bomber_pkg::tile_free);
        move_seen = 1'b1;
      end
      next_cycle();
    end
    repeat (2) check_move(bomb_cell, bomber_pkg::dir_t'(rand_below(4)));
  endtask

  // game_over in the middle of the fuse
  task automatic abort_bomb();
    int hold;
    hold = 2 + rand_below(FUSE_CYCLES - 4);
    bomb_addr = ADDR_W'(random_interior());
    bomb_drop = 1'b1;
    next_cycle();
    bomb_drop = 1'b0;
    check_bit("bomb_armed", bomb_armed, 1'b1);
    repeat (hold) next_cycle();
    game_over = 1'b1;
    next_cycle();
    game_over = 1'b0;
    check_bit("bomb_armed", bomb_armed, 1'b0);
    check_bit("blast_busy", blast_busy, 1'b0);
    repeat (FUSE_CYCLES + 8) begin
      next_cycle();
      check_bit("bomb_armed", bomb_armed, 1'b0);
      check_bit("blast_busy", blast_busy, 1'b0);
      check_bit("blast_done", blast_done, 1'b0);
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    int               target;
    bomber_pkg::dir_t dir;
    game_over = 1'b0;
    bomb_drop = 1'b0;
    bomb_addr = '0;
    move_req  = 1'b0;
    move_addr = '0;
    move_dir  = bomber_pkg::dir_up;
    seed      = 32'h8e3b;
    for (int r = 0; r < NUM_ROW; r++) begin
      for (int c = 0; c < NUM_COL; c++) model[r * NUM_COL + c] = pattern_tile(r, c);
    end
    wait (rst_n === 1'b1);
    check_bit("bomb_armed", bomb_armed, 1'b0);
    check_bit("blast_busy", blast_busy, 1'b0);
    check_bit("blast_done", blast_done, 1'b0);
    check_bit("move_done", move_done, 1'b0);
    repeat (16) begin
      target = random_interior();
      dir    = bomber_pkg::dir_t'(rand_below(4));
      check_move(step_cell(target, opposite_dir(dir)), dir);
    end
    repeat (4) drop_on_border();
    repeat (8) run_bomb();
    repeat (2) abort_bomb();
    $display("Test passed");
    $finish;
  end

endmodule

//--- compile.f
logic/bomber_pkg.sv
logic/map_mem.sv
logic/map_read_arbiter.sv
logic/bomb_timer.sv
logic/blast_clearer.sv
logic/move_checker.sv
logic/bomber_map_top.sv
tb/clk_gen.sv
tb/tb_bomber_map.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_bomber_map -f compile.f -o sim_bomber_map &&
  ./obj_dir/sim_bomber_map ||
  { echo "Simulation failed"; exit 1; }
